//--- dv/tb_asic_cfg.sv
`timescale 1ns/10ps

module tb_asic_cfg;

  localparam int TIMEOUT = 100;   // Cycles allowed for any valid or ready

  logic        ACLK;
  logic        ARESETn;
  logic [7:0]  AWID_i, ARID_i, BID_o, RID_o;
  logic [31:0] AWADDR_i, ARADDR_i, WDATA_i, RDATA_o;
  logic        AWVALID_i, AWREADY_o, WLAST_i, WVALID_i, WREADY_o;
  logic [1:0]  BRESP_o, RRESP_o;
  logic        BVALID_o, BREADY_i, ARVALID_i, ARREADY_o;
  logic        RLAST_o, RVALID_o, RREADY_i;
  logic        asic_done_i;
  logic        asic_en_o, maxpool_o, relu_o, operation_mode_o;
  logic [5:0]  scaling_factor_o;
  logic [9:0]  map_m_o, shape_c_o, shape_m_o;
  logic [3:0]  map_e_o;
  logic [1:0]  map_p_o, map_q_o, map_r_o, map_t_o;
  logic [7:0]  shape_w_o, shape_h_o;
  logic [31:0] ifmap_addr_o, filter_addr_o, bias_addr_o, opsum_addr_o;
  logic [31:0] glb_filter_addr_o, glb_ofmap_addr_o, glb_bias_addr_o;
  logic [31:0] ifmap_len_o, ofmap_len_o;

  logic [31:0] lfsr_q;
  logic [31:0] model [13];   // Expected register file
  logic [31:0] beats [3];    // W data of the next write

  asic_cfg_top uut (.*);

  always #4 ACLK = ~ACLK;

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check(input logic [31:0] act, input logic [31:0] exp, input string what);
    if (act !== exp) begin
      $display("[ERROR] t=%0t: %s is 0x%08h, expected 0x%08h", $time, what, act, exp);
      $display("Simulation failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("No %s from the DUT within %0d cycles", what, TIMEOUT);
    $display("Simulation failed");
    $fatal(1, "Handshake timeout");
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [7:0] id, input int nbeats,
                           input int bdelay, output logic [1:0] resp, output logic [7:0] bid);
    int cnt;
    @(negedge ACLK);
    AWADDR_i  = addr;
    AWID_i    = id;
    AWVALID_i = 1'b1;
    #2;
    cnt = 0;
    while (!AWREADY_o) begin
      @(negedge ACLK);
      #2;
      cnt++;
      if (cnt > TIMEOUT) give_up("AWREADY");
    end
    for (int i = 0; i < nbeats; i++) begin
      @(negedge ACLK);
      AWVALID_i = 1'b0;
      WDATA_i   = beats[i];
      WLAST_i   = (i == nbeats - 1);
      WVALID_i  = 1'b1;
      #2;
      cnt = 0;
      while (!WREADY_o) begin
        @(negedge ACLK);
        #2;
        cnt++;
        if (cnt > TIMEOUT) give_up("WREADY");
      end
    end
    @(negedge ACLK);
    WVALID_i = 1'b0;
    WLAST_i  = 1'b0;
    #2;
    cnt = 0;
    while (!BVALID_o) begin
      @(negedge ACLK);
      #2;
      cnt++;
      if (cnt > TIMEOUT) give_up("BVALID");
    end
    resp = BRESP_o;
    bid  = BID_o;
    repeat (bdelay) begin   // Master stalls, response must hold
      @(negedge ACLK);
      #2;
      check(32'(BVALID_o), 32'd1, "BVALID under back-pressure");
      check(32'(BRESP_o), 32'(resp), "BRESP under back-pressure");
      check(32'(BID_o), 32'(bid), "BID under back-pressure");
    end
    @(negedge ACLK);
    BREADY_i = 1'b1;
    @(negedge ACLK);
    BREADY_i = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, input logic [7:0] id, input int rdelay,
                          output logic [31:0] data, output logic [1:0] resp,
                          output logic [7:0] rid);
    int cnt;
    @(negedge ACLK);
    ARADDR_i  = addr;
    ARID_i    = id;
    ARVALID_i = 1'b1;
    #2;
    cnt = 0;
    while (!ARREADY_o) begin
      @(negedge ACLK);
      #2;
      cnt++;
      if (cnt > TIMEOUT) give_up("ARREADY");
    end
    @(negedge ACLK);
    ARVALID_i = 1'b0;
    #2;
    cnt = 0;
    while (!RVALID_o) begin
      @(negedge ACLK);
      #2;
      cnt++;
      if (cnt > TIMEOUT) give_up("RVALID");
    end
    check(32'(RLAST_o), 32'd1, "RLAST on the only beat");
    data = RDATA_o;
    resp = RRESP_o;
    rid  = RID_o;
    repeat (rdelay) begin
      @(negedge ACLK);
      #2;
      check(32'(RVALID_o), 32'd1, "RVALID under back-pressure");
      check(RDATA_o, data, "RDATA under back-pressure");
      check(32'(RRESP_o), 32'(resp), "RRESP under back-pressure");
      check(32'(RID_o), 32'(rid), "RID under back-pressure");
    end
    @(negedge ACLK);
    RREADY_i = 1'b1;
    @(negedge ACLK);
    RREADY_i = 1'b0;
  endtask

  // Random ID and BREADY delay
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    logic [31:0] r;
    logic [1:0]  resp;
    logic [7:0]  bid;
    take_bits(11, r);
    beats[0] = data;
    axi_write(addr, r[7:0], 1, int'(r[10:8]), resp, bid);
    check(32'(resp), 32'(exp_resp), "BRESP");
    check(32'(bid), 32'(r[7:0]), "BID");
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp_data,
                          input logic [1:0] exp_resp);
    logic [31:0] r;
    logic [31:0] data;
    logic [1:0]  resp;
    logic [7:0]  rid;
    take_bits(11, r);
    axi_read(addr, r[7:0], int'(r[10:8]), data, resp, rid);
    check(data, exp_data, "RDATA");
    check(32'(resp), 32'(exp_resp), "RRESP");
    check(32'(rid), 32'(r[7:0]), "RID");
  endtask

  task automatic read_all_check();
    for (int i = 0; i < 13; i++) begin
      read_reg(32'(i * 4), model[i], cfg_pkg::RESP_OKAY);
    end
  endtask

  // Field order follows the bit positions of each word
  task automatic check_fields();
    check(32'({scaling_factor_o, operation_mode_o, relu_o, maxpool_o, asic_en_o}),
          32'(model[0][9:0]), "enable fields");
    check(32'({map_m_o, map_e_o, map_p_o, map_q_o, map_r_o, map_t_o}),
          32'(model[1][21:0]), "mapping fields");
    check(32'({shape_c_o, shape_m_o}), 32'(model[2][19:0]), "shape1 fields");
    check(32'({shape_w_o, shape_h_o}), 32'(model[3][15:0]), "shape2 fields");
  endtask

  task automatic check_ports();
    check(ifmap_addr_o, model[4], "ifmap_addr_o");
    check(filter_addr_o, model[5], "filter_addr_o");
    check(bias_addr_o, model[6], "bias_addr_o");
    check(opsum_addr_o, model[7], "opsum_addr_o");
    check(glb_filter_addr_o, model[8], "glb_filter_addr_o");
    check(glb_ofmap_addr_o, model[9], "glb_ofmap_addr_o");
    check(glb_bias_addr_o, model[10], "glb_bias_addr_o");
    check(ifmap_len_o, model[11], "ifmap_len_o");
    check(ofmap_len_o, model[12], "ofmap_len_o");
  endtask

  task automatic test_reset_values();
    read_all_check();
    check_fields();
    check_ports();
  endtask

  task automatic test_write_readback();
    logic [31:0] d;
    for (int i = 0; i < 13; i++) begin
      take_bits(32, d);
      model[i] = d;
      write_reg(32'(i * 4), d, cfg_pkg::RESP_OKAY);
      read_reg(32'(i * 4), d, cfg_pkg::RESP_OKAY);
    end
    check_ports();
  endtask

  task automatic test_field_decode();
    logic [31:0] d;
    for (int i = 0; i < 4; i++) begin
      take_bits(32, d);
      model[i] = d;
      write_reg(32'(i * 4), d, cfg_pkg::RESP_OKAY);
      check_fields();
    end
  endtask

  task automatic test_bad_address();
    logic [31:0] bad [2];
    logic [31:0] d;
    bad[0] = 32'h34;   // Past the last register
    bad[1] = 32'h6;    // Misaligned
    for (int i = 0; i < 2; i++) begin
      take_bits(32, d);
      write_reg(bad[i], d, cfg_pkg::RESP_SLVERR);
      read_reg(bad[i], 32'h0, cfg_pkg::RESP_SLVERR);
    end
    read_all_check();
    check_fields();
    check_ports();
  endtask

  task automatic test_burst();
    logic [31:0] r;
    logic [1:0]  resp;
    logic [7:0]  bid;
    for (int i = 0; i < 3; i++) begin
      take_bits(32, beats[i]);
    end
    take_bits(11, r);
    axi_write(cfg_pkg::OFS_FILTER_ADDR, r[7:0], 3, int'(r[10:8]), resp, bid);
    check(32'(resp), 32'(cfg_pkg::RESP_OKAY), "burst BRESP");
    check(32'(bid), 32'(r[7:0]), "burst BID");
    check(32'(BVALID_o), 32'd0, "single B response per burst");
    model[5] = beats[2];   // Last beat wins
    read_all_check();
  endtask

  task automatic test_done_clear();
    cfg_pkg::cfg_word_u w;
    logic [31:0]        r;
    take_bits(32, r);
    w.raw      = r;
    w.en.start = 1'b1;
    model[0]   = w.raw;
    write_reg(cfg_pkg::OFS_ENABLE, w.raw, cfg_pkg::RESP_OKAY);
    check(32'(asic_en_o), 32'd1, "asic_en_o before done");
    @(negedge ACLK);
    asic_done_i = 1'b1;
    @(negedge ACLK);
    asic_done_i = 1'b0;
    #2;
    w.en.start = 1'b0;
    model[0]   = w.raw;
    check(32'(asic_en_o), 32'd0, "asic_en_o after done");
    read_reg(cfg_pkg::OFS_ENABLE, model[0], cfg_pkg::RESP_OKAY);
    check_fields();
  endtask

  initial begin
    ACLK        = 1'b0;
    ARESETn     = 1'b0;
    AWID_i      = '0;
    AWADDR_i    = '0;
    AWVALID_i   = 1'b0;
    WDATA_i     = '0;
    WLAST_i     = 1'b0;
    WVALID_i    = 1'b0;
    BREADY_i    = 1'b0;
    ARID_i      = '0;
    ARADDR_i    = '0;
    ARVALID_i   = 1'b0;
    RREADY_i    = 1'b0;
    asic_done_i = 1'b0;
    lfsr_q      = 32'h9282_7c35;
    foreach (model[i]) model[i] = '0;
    foreach (beats[i]) beats[i] = '0;
    repeat (8) @(posedge ACLK);
    @(negedge ACLK);
    ARESETn = 1'b1;

    test_reset_values();
    test_write_readback();
    test_field_decode();
    test_bad_address();
    test_burst();
    test_done_clear();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- logic/asic_cfg_top.sv
`timescale 1ns/10ps

module asic_cfg_top (
  input  logic                          ACLK,
  input  logic                          ARESETn,

  input  logic [cfg_pkg::ID_BITS-1:0]   AWID_i,
  input  logic [cfg_pkg::ADDR_BITS-1:0] AWADDR_i,
  input  logic                          AWVALID_i,
  output logic                          AWREADY_o,

  input  logic [cfg_pkg::DATA_BITS-1:0] WDATA_i,
  input  logic                          WLAST_i,
  input  logic                          WVALID_i,
  output logic                          WREADY_o,

  output logic [cfg_pkg::ID_BITS-1:0]   BID_o,
  output logic [1:0]                    BRESP_o,
  output logic                          BVALID_o,
  input  logic                          BREADY_i,

  input  logic [cfg_pkg::ID_BITS-1:0]   ARID_i,
  input  logic [cfg_pkg::ADDR_BITS-1:0] ARADDR_i,
  input  logic                          ARVALID_i,
  output logic                          ARREADY_o,

  output logic [cfg_pkg::ID_BITS-1:0]   RID_o,
  output logic [cfg_pkg::DATA_BITS-1:0] RDATA_o,
  output logic [1:0]                    RRESP_o,
  output logic                          RLAST_o,
  output logic                          RVALID_o,
  input  logic                          RREADY_i,

  input  logic                          asic_done_i,

  // Array control fields
  output logic                          asic_en_o,
  output logic                          maxpool_o,
  output logic                          relu_o,
  output logic                          operation_mode_o,
  output logic [5:0]                    scaling_factor_o,
  output logic [9:0]                    map_m_o,
  output logic [3:0]                    map_e_o,
  output logic [1:0]                    map_p_o,
  output logic [1:0]                    map_q_o,
  output logic [1:0]                    map_r_o,
  output logic [1:0]                    map_t_o,
  output logic [9:0]                    shape_c_o,
  output logic [9:0]                    shape_m_o,
  output logic [7:0]                    shape_w_o,
  output logic [7:0]                    shape_h_o,

  // DRAM and GLB addresses, transfer lengths
  output logic [cfg_pkg::DATA_BITS-1:0] ifmap_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] filter_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] bias_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] opsum_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] glb_filter_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] glb_ofmap_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] glb_bias_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] ifmap_len_o,
  output logic [cfg_pkg::DATA_BITS-1:0] ofmap_len_o
);

  reg_access_if acc ();

  cfg_pkg::cfg_word_u enable_w;
  cfg_pkg::cfg_word_u mapping_w;
  cfg_pkg::cfg_word_u shape1_w;
  cfg_pkg::cfg_word_u shape2_w;

  axi_cfg_slave_fsm u_fsm (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .awid_i    (AWID_i),
    .awaddr_i  (AWADDR_i),
    .awvalid_i (AWVALID_i),
    .awready_o (AWREADY_o),
    .wdata_i   (WDATA_i),
    .wlast_i   (WLAST_i),
    .wvalid_i  (WVALID_i),
    .wready_o  (WREADY_o),
    .bid_o     (BID_o),
    .bresp_o   (BRESP_o),
    .bvalid_o  (BVALID_o),
    .bready_i  (BREADY_i),
    .arid_i    (ARID_i),
    .araddr_i  (ARADDR_i),
    .arvalid_i (ARVALID_i),
    .arready_o (ARREADY_o),
    .rid_o     (RID_o),
    .rdata_o   (RDATA_o),
    .rresp_o   (RRESP_o),
    .rlast_o   (RLAST_o),
    .rvalid_o  (RVALID_o),
    .rready_i  (RREADY_i),
    .acc       (acc.fsm)
  );

  cfg_reg_bank u_bank (
    .ACLK              (ACLK),
    .ARESETn           (ARESETn),
    .acc               (acc.bank),
    .asic_done_i       (asic_done_i),
    .enable_o          (enable_w.raw),
    .mapping_o         (mapping_w.raw),
    .shape1_o          (shape1_w.raw),
    .shape2_o          (shape2_w.raw),
    .ifmap_addr_o      (ifmap_addr_o),
    .filter_addr_o     (filter_addr_o),
    .bias_addr_o       (bias_addr_o),
    .opsum_addr_o      (opsum_addr_o),
    .glb_filter_addr_o (glb_filter_addr_o),
    .glb_ofmap_addr_o  (glb_ofmap_addr_o),
    .glb_bias_addr_o   (glb_bias_addr_o),
    .ifmap_len_o       (ifmap_len_o),
    .ofmap_len_o       (ofmap_len_o)
  );

  assign asic_en_o        = enable_w.en.start;
  assign maxpool_o        = enable_w.en.maxpool;
  assign relu_o           = enable_w.en.relu;
  assign operation_mode_o = enable_w.en.operation_mode;
  assign scaling_factor_o = enable_w.en.scaling_factor;

  assign map_m_o = mapping_w.map.m;
  assign map_e_o = mapping_w.map.e;
  assign map_p_o = mapping_w.map.p;
  assign map_q_o = mapping_w.map.q;
  assign map_r_o = mapping_w.map.r;
  assign map_t_o = mapping_w.map.t;

  assign shape_c_o = shape1_w.shape1.c;
  assign shape_m_o = shape1_w.shape1.m;
  assign shape_w_o = shape2_w.shape2.w;
  assign shape_h_o = shape2_w.shape2.h;

endmodule

//--- logic/axi_cfg_slave_fsm.sv
`timescale 1ns/10ps

module axi_cfg_slave_fsm (
  input  logic                          ACLK,
  input  logic                          ARESETn,

  input  logic [cfg_pkg::ID_BITS-1:0]   awid_i,
  input  logic [cfg_pkg::ADDR_BITS-1:0] awaddr_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,

  input  logic [cfg_pkg::DATA_BITS-1:0] wdata_i,
  input  logic                          wlast_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,

  output logic [cfg_pkg::ID_BITS-1:0]   bid_o,
  output logic [1:0]                    bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,

  input  logic [cfg_pkg::ID_BITS-1:0]   arid_i,
  input  logic [cfg_pkg::ADDR_BITS-1:0] araddr_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,

  output logic [cfg_pkg::ID_BITS-1:0]   rid_o,
  output logic [cfg_pkg::DATA_BITS-1:0] rdata_o,
  output logic [1:0]                    rresp_o,
  output logic                          rlast_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,

  reg_access_if.fsm                     acc
);

  cfg_pkg::slave_state_e          state;
  logic [cfg_pkg::ADDR_BITS-1:0]  addr_q;
  logic                           wr_err; // Sticky over the whole burst

  // Address channels, write wins when both arrive together
  assign awready_o = (state == cfg_pkg::ST_IDLE) && awvalid_i;
  assign arready_o = (state == cfg_pkg::ST_IDLE) && !awvalid_i && arvalid_i;

  assign wready_o  = (state == cfg_pkg::ST_WRITE_DATA);

  assign acc.wr_en = wready_o && wvalid_i;
  assign acc.addr  = addr_q;
  assign acc.wdata = wdata_i;

  assign bvalid_o = (state == cfg_pkg::ST_WRITE_RESP);
  assign bresp_o  = wr_err ? cfg_pkg::RESP_SLVERR : cfg_pkg::RESP_OKAY;

  // Single beat reads, so every beat is the last
  assign rvalid_o = (state == cfg_pkg::ST_READ_DATA);
  assign rlast_o  = rvalid_o;
  assign rdata_o  = rvalid_o ? acc.rdata : '0;
  assign rresp_o  = (rvalid_o && !acc.addr_hit) ? cfg_pkg::RESP_SLVERR
                                                : cfg_pkg::RESP_OKAY;

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state  <= cfg_pkg::ST_IDLE;
      addr_q <= '0;
      bid_o  <= '0;
      rid_o  <= '0;
      wr_err <= 1'b0;
    end else begin
      case (state)
        cfg_pkg::ST_IDLE: begin
          if (awready_o) begin
            addr_q <= awaddr_i;
            bid_o  <= awid_i;
            wr_err <= 1'b0;     // Fresh write
            state  <= cfg_pkg::ST_WRITE_DATA;
          end else if (arready_o) begin
            addr_q <= araddr_i;
            rid_o  <= arid_i;
            state  <= cfg_pkg::ST_READ_DATA;
          end
        end
        cfg_pkg::ST_WRITE_DATA: begin
          if (acc.wr_en) begin
            if (!acc.addr_hit) wr_err <= 1'b1;
            if (wlast_i) state <= cfg_pkg::ST_WRITE_RESP;
          end
        end
        cfg_pkg::ST_WRITE_RESP: begin
          if (bready_i) state <= cfg_pkg::ST_IDLE;
        end
        cfg_pkg::ST_READ_DATA: begin
          if (rready_i) state <= cfg_pkg::ST_IDLE;
        end
        default: state <= cfg_pkg::ST_IDLE;
      endcase
    end
  end

  // Response must hold with its ID and code until the master takes it
  a_bvalid_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o) && $stable(bid_o));

  a_rvalid_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rresp_o) && $stable(rid_o));

  // Last beat closes the burst, no further strobes reach the bank
  a_wr_en_burst_end: assert property (@(posedge ACLK) disable iff (!ARESETn)
    acc.wr_en && wlast_i |=> !acc.wr_en && bvalid_o);

endmodule

//--- logic/cfg_pkg.sv
package cfg_pkg;

  // Bus widths
  localparam int unsigned ADDR_BITS = 32;
  localparam int unsigned DATA_BITS = 32;
  localparam int unsigned ID_BITS   = 8;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam int unsigned NUM_REGS = 13;

  // Register map, byte offsets
  localparam logic [ADDR_BITS-1:0] OFS_ENABLE          = 32'h0000_0000;
  localparam logic [ADDR_BITS-1:0] OFS_MAPPING         = 32'h0000_0004;
  localparam logic [ADDR_BITS-1:0] OFS_SHAPE1          = 32'h0000_0008;
  localparam logic [ADDR_BITS-1:0] OFS_SHAPE2          = 32'h0000_000C;
  localparam logic [ADDR_BITS-1:0] OFS_IFMAP_ADDR      = 32'h0000_0010;
  localparam logic [ADDR_BITS-1:0] OFS_FILTER_ADDR     = 32'h0000_0014;
  localparam logic [ADDR_BITS-1:0] OFS_BIAS_ADDR       = 32'h0000_0018;
  localparam logic [ADDR_BITS-1:0] OFS_OPSUM_ADDR      = 32'h0000_001C;
  localparam logic [ADDR_BITS-1:0] OFS_GLB_FILTER_ADDR = 32'h0000_0020;
  localparam logic [ADDR_BITS-1:0] OFS_GLB_OFMAP_ADDR  = 32'h0000_0024;
  localparam logic [ADDR_BITS-1:0] OFS_GLB_BIAS_ADDR   = 32'h0000_0028;
  localparam logic [ADDR_BITS-1:0] OFS_IFMAP_LEN       = 32'h0000_002C;
  localparam logic [ADDR_BITS-1:0] OFS_OFMAP_LEN       = 32'h0000_0030;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE_DATA,
    ST_WRITE_RESP,
    ST_READ_DATA
  } slave_state_e;

  // ENABLE word
  typedef struct packed {
    logic [21:0] rsvd;
    logic [5:0]  scaling_factor;
    logic        operation_mode;
    logic        relu;
    logic        maxpool;
    logic        start;          // Kicks off the array, cleared by done
  } enable_view_t;

  // MAPPING word, PE set tiling
  typedef struct packed {
    logic [9:0] rsvd;
    logic [9:0] m;               // Ofmap channels held in GLB
    logic [3:0] e;               // PE set width
    logic [1:0] p;
    logic [1:0] q;
    logic [1:0] r;
    logic [1:0] t;
  } mapping_view_t;

  typedef struct packed {
    logic [11:0] rsvd;
    logic [9:0]  c;
    logic [9:0]  m;
  } shape1_view_t;

  typedef struct packed {
    logic [15:0] rsvd;
    logic [7:0]  w;
    logic [7:0]  h;
  } shape2_view_t;

  // One config word, raw over AXI or split into fields for the array
  typedef union packed {
    logic [DATA_BITS-1:0] raw;
    enable_view_t         en;
    mapping_view_t        map;
    shape1_view_t         shape1;
    shape2_view_t         shape2;
  } cfg_word_u;

endpackage

//--- logic/cfg_reg_bank.sv
`timescale 1ns/10ps

module cfg_reg_bank (
  input  logic                          ACLK,
  input  logic                          ARESETn,

  reg_access_if.bank                    acc,
  input  logic                          asic_done_i,

  output logic [cfg_pkg::DATA_BITS-1:0] enable_o,
  output logic [cfg_pkg::DATA_BITS-1:0] mapping_o,
  output logic [cfg_pkg::DATA_BITS-1:0] shape1_o,
  output logic [cfg_pkg::DATA_BITS-1:0] shape2_o,
  output logic [cfg_pkg::DATA_BITS-1:0] ifmap_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] filter_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] bias_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] opsum_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] glb_filter_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] glb_ofmap_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] glb_bias_addr_o,
  output logic [cfg_pkg::DATA_BITS-1:0] ifmap_len_o,
  output logic [cfg_pkg::DATA_BITS-1:0] ofmap_len_o
);

  // Register file in offset order
  logic [cfg_pkg::NUM_REGS-1:0][cfg_pkg::DATA_BITS-1:0] regs;
  logic [$clog2(cfg_pkg::NUM_REGS)-1:0]                  sel;

  // Exact match only, misaligned offsets miss
  always_comb begin
    acc.addr_hit = 1'b1;
    sel          = 4'd0;
    case (acc.addr)
      cfg_pkg::OFS_ENABLE:          sel = 4'd0;
      cfg_pkg::OFS_MAPPING:         sel = 4'd1;
      cfg_pkg::OFS_SHAPE1:          sel = 4'd2;
      cfg_pkg::OFS_SHAPE2:          sel = 4'd3;
      cfg_pkg::OFS_IFMAP_ADDR:      sel = 4'd4;
      cfg_pkg::OFS_FILTER_ADDR:     sel = 4'd5;
      cfg_pkg::OFS_BIAS_ADDR:       sel = 4'd6;
      cfg_pkg::OFS_OPSUM_ADDR:      sel = 4'd7;
      cfg_pkg::OFS_GLB_FILTER_ADDR: sel = 4'd8;
      cfg_pkg::OFS_GLB_OFMAP_ADDR:  sel = 4'd9;
      cfg_pkg::OFS_GLB_BIAS_ADDR:   sel = 4'd10;
      cfg_pkg::OFS_IFMAP_LEN:       sel = 4'd11;
      cfg_pkg::OFS_OFMAP_LEN:       sel = 4'd12;
      default:                      acc.addr_hit = 1'b0;
    endcase
  end

  assign acc.rdata = acc.addr_hit ? regs[sel] : '0;

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      regs <= '0;
    end else begin
      if (asic_done_i) regs[0][0] <= 1'b0;   // Array finished, drop start
      // Later assignment, so a host write to ENABLE beats done
      if (acc.wr_en && acc.addr_hit) regs[sel] <= acc.wdata;
    end
  end

  assign enable_o          = regs[0];
  assign mapping_o         = regs[1];
  assign shape1_o          = regs[2];
  assign shape2_o          = regs[3];
  assign ifmap_addr_o      = regs[4];
  assign filter_addr_o     = regs[5];
  assign bias_addr_o       = regs[6];
  assign opsum_addr_o      = regs[7];
  assign glb_filter_addr_o = regs[8];
  assign glb_ofmap_addr_o  = regs[9];
  assign glb_bias_addr_o   = regs[10];
  assign ifmap_len_o       = regs[11];
  assign ofmap_len_o       = regs[12];

  // A rejected beat must leave the whole file untouched
  a_no_stray_write: assert property (@(posedge ACLK) disable iff (!ARESETn)
    acc.wr_en && !acc.addr_hit && !asic_done_i |=> $stable(regs));

endmodule

//--- logic/reg_access_if.sv
`timescale 1ns/10ps

interface reg_access_if;

  logic                           wr_en;    // One strobe per write beat
  logic [cfg_pkg::ADDR_BITS-1:0]  addr;
  logic [cfg_pkg::DATA_BITS-1:0]  wdata;
  logic [cfg_pkg::DATA_BITS-1:0]  rdata;
  logic                           addr_hit; // Address is a real register

  modport fsm (
    output wr_en,
    output addr,
    output wdata,
    input  rdata,
    input  addr_hit
  );

  modport bank (
    input  wr_en,
    input  addr,
    input  wdata,
    output rdata,
    output addr_hit
  );

endinterface

//--- run.sh
#!/usr/bin/env bash
# Builds the config slave testbench with Verilator and runs it.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_asic_cfg \
  -Mdir obj_dir \
  -f tb.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/Vtb_asic_cfg
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation run failed with status $sim_status"
  exit "$sim_status"
fi

exit 0

//--- tb.f
logic/cfg_pkg.sv
logic/reg_access_if.sv
logic/axi_cfg_slave_fsm.sv
logic/cfg_reg_bank.sv
logic/asic_cfg_top.sv
dv/tb_asic_cfg.sv
